/* hw/tcu_config.svh */
/*
 * Tensor-core issue configuration
 * Tile step counts, sub-block counts, base float registers of the
 * A, B and C tiles, UUID width and instruction buffer depth
 */
`ifndef TCU_CONFIG_SVH
`define TCU_CONFIG_SVH

// Steps along each tile axis
`define TCU_M_STEPS 2
`define TCU_N_STEPS 2
`define TCU_K_STEPS 2

// A and B tiles are spread over this many register sub-blocks
`define TCU_A_SUB_BLOCKS 2
`define TCU_B_SUB_BLOCKS 1

// Base float registers, 5-bit indices
`define TCU_RA 8
`define TCU_RB 16
`define TCU_RC 24

`define UUID_WIDTH 32

`define IBUF_DEPTH 4

`endif

/* hw/gpu_pkg.sv */
/*
 * Instruction-stream types
 * Execution units, register files and the register number layout
 * shared by the buffer, the expander and the micro-op generator
 */
package gpu_pkg;

    localparam int pc_w      = 32;
    localparam int tmask_w   = 4;
    localparam int op_type_w = 4;

    // A register number is the file bit over a 5-bit index
    localparam int reg_num_w = 6;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_SFU,
        EX_TCU
    } ex_type_e;

    typedef enum logic {
        REG_INT,
        REG_FLOAT
    } reg_type_e;

    function automatic logic [reg_num_w-1:0] make_reg_num(reg_type_e rtype, logic [4:0] idx);
        return {rtype, idx};
    endfunction

endpackage

/* hw/tcu_pkg.sv */
/*
 * Tensor-core types
 * TCU opcodes and data formats, plus the micro-op count and the
 * index widths derived from the tile configuration
 */
`include "tcu_config.svh"

package tcu_pkg;

    // Carried in the op_type field of a TCU instruction
    typedef enum logic [gpu_pkg::op_type_w-1:0] {
        TCU_MMA  = 4'd0,
        TCU_ZERO = 4'd1
    } tcu_op_e;

    typedef enum logic [2:0] {
        FMT_FP16,
        FMT_BF16,
        FMT_FP32,
        FMT_INT8
    } tcu_fmt_e;

    localparam int TCU_UOPS  = `TCU_M_STEPS * `TCU_N_STEPS * `TCU_K_STEPS;
    localparam int TCU_CTR_W = (TCU_UOPS > 1) ? $clog2(TCU_UOPS) : 1;

    localparam int TCU_LG_M    = $clog2(`TCU_M_STEPS);
    localparam int TCU_LG_N    = $clog2(`TCU_N_STEPS);
    localparam int TCU_LG_K    = $clog2(`TCU_K_STEPS);
    localparam int TCU_LG_A_SB = $clog2(`TCU_A_SUB_BLOCKS);
    localparam int TCU_LG_B_SB = $clog2(`TCU_B_SUB_BLOCKS);

endpackage

/* hw/ibuffer_fifo.sv */
/*
 * Instruction buffer
 * Circular FIFO of decoded instructions with valid/ready on the write
 * side and a combinational head with a pop strobe on the read side
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module ibuffer_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`UUID_WIDTH-1:0]          in_uuid,
    input  logic [gpu_pkg::tmask_w-1:0]     in_tmask,
    input  logic [gpu_pkg::pc_w-1:0]        in_pc,
    input  gpu_pkg::ex_type_e               in_ex_type,
    input  logic [gpu_pkg::op_type_w-1:0]   in_op_type,
    input  tcu_pkg::tcu_fmt_e               in_fmt_s,
    input  tcu_pkg::tcu_fmt_e               in_fmt_d,
    input  logic                            in_wb,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rd,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs1,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs2,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs3,
    input  logic                            in_valid,
    output logic                            in_ready,
    output logic [`UUID_WIDTH-1:0]          head_uuid,
    output logic [gpu_pkg::tmask_w-1:0]     head_tmask,
    output logic [gpu_pkg::pc_w-1:0]        head_pc,
    output gpu_pkg::ex_type_e               head_ex_type,
    output logic [gpu_pkg::op_type_w-1:0]   head_op_type,
    output tcu_pkg::tcu_fmt_e               head_fmt_s,
    output tcu_pkg::tcu_fmt_e               head_fmt_d,
    output logic                            head_wb,
    output logic [gpu_pkg::reg_num_w-1:0]   head_rd,
    output logic [gpu_pkg::reg_num_w-1:0]   head_rs1,
    output logic [gpu_pkg::reg_num_w-1:0]   head_rs2,
    output logic [gpu_pkg::reg_num_w-1:0]   head_rs3,
    output logic                            head_valid,
    input  logic                            head_pop
);
    import gpu_pkg::*;
    import tcu_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef struct packed {
        logic [`UUID_WIDTH-1:0] uuid;
        logic [tmask_w-1:0]     tmask;
        logic [pc_w-1:0]        pc;
        ex_type_e               ex_type;
        logic [op_type_w-1:0]   op_type;
        tcu_fmt_e               fmt_s;
        tcu_fmt_e               fmt_d;
        logic                   wb;
        logic [reg_num_w-1:0]   rd;
        logic [reg_num_w-1:0]   rs1;
        logic [reg_num_w-1:0]   rs2;
        logic [reg_num_w-1:0]   rs3;
    } word_t;

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;

    // Pointers wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready   = (count != (PTR_W + 1)'(DEPTH));
    assign head_valid = (count != '0);
    assign push       = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= '{in_uuid, in_tmask, in_pc, in_ex_type, in_op_type, in_fmt_s,
                             in_fmt_d, in_wb, in_rd, in_rs1, in_rs2, in_rs3};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (head_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign head_uuid    = mem[rd_ptr].uuid;
    assign head_tmask   = mem[rd_ptr].tmask;
    assign head_pc      = mem[rd_ptr].pc;
    assign head_ex_type = mem[rd_ptr].ex_type;
    assign head_op_type = mem[rd_ptr].op_type;
    assign head_fmt_s   = mem[rd_ptr].fmt_s;
    assign head_fmt_d   = mem[rd_ptr].fmt_d;
    assign head_wb      = mem[rd_ptr].wb;
    assign head_rd      = mem[rd_ptr].rd;
    assign head_rs1     = mem[rd_ptr].rs1;
    assign head_rs2     = mem[rd_ptr].rs2;
    assign head_rs3     = mem[rd_ptr].rs3;

    // The expander must never pop an empty buffer
    assert property (@(posedge clk) disable iff (reset) head_pop |-> head_valid)
        else $error("ibuffer_fifo: pop while empty");

endmodule

/* hw/tcu_uops.sv */
/*
 * TCU micro-op generator
 * Steps a counter through the N, M and K tile indices of an MMA and
 * derives each micro-op's step fields, float registers and UUID
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module tcu_uops (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`UUID_WIDTH-1:0]          in_uuid,
    input  logic [gpu_pkg::tmask_w-1:0]     in_tmask,
    input  logic [gpu_pkg::pc_w-1:0]        in_pc,
    input  gpu_pkg::ex_type_e               in_ex_type,
    input  logic [gpu_pkg::op_type_w-1:0]   in_op_type,
    input  tcu_pkg::tcu_fmt_e               in_fmt_s,
    input  tcu_pkg::tcu_fmt_e               in_fmt_d,
    input  logic                            start,
    input  logic                            next,
    output logic                            done,
    output logic [`UUID_WIDTH-1:0]          out_uuid,
    output logic [gpu_pkg::tmask_w-1:0]     out_tmask,
    output logic [gpu_pkg::pc_w-1:0]        out_pc,
    output gpu_pkg::ex_type_e               out_ex_type,
    output logic [gpu_pkg::op_type_w-1:0]   out_op_type,
    output tcu_pkg::tcu_fmt_e               out_fmt_s,
    output tcu_pkg::tcu_fmt_e               out_fmt_d,
    output logic                            out_wb,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rd,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs1,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs2,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs3,
    output logic [3:0]                      out_step_m,
    output logic [3:0]                      out_step_n
);
    import gpu_pkg::*;
    import tcu_pkg::*;

    logic [TCU_CTR_W-1:0] counter;
    logic                 busy;
    logic [TCU_CTR_W-1:0] n_idx;
    logic [TCU_CTR_W-1:0] m_idx;
    logic [TCU_CTR_W-1:0] k_idx;
    logic [TCU_CTR_W-1:0] rs1_off;
    logic [TCU_CTR_W-1:0] rs2_off;
    logic [TCU_CTR_W-1:0] rs3_off;

    // Counter reads as {k, m, n} with N fastest; for power-of-two steps
    // these reduce to plain bit slices
    assign n_idx = TCU_CTR_W'(counter % `TCU_N_STEPS);
    assign m_idx = TCU_CTR_W'((counter / `TCU_N_STEPS) % `TCU_M_STEPS);
    assign k_idx = TCU_CTR_W'(counter / (`TCU_N_STEPS * `TCU_M_STEPS));

    // Offsets of the A, B and C tiles inside their register blocks
    assign rs1_off = ((m_idx >> TCU_LG_A_SB) << TCU_LG_K) | k_idx;
    assign rs2_off = ((k_idx << TCU_LG_N) | n_idx) >> TCU_LG_B_SB;
    assign rs3_off = (m_idx << TCU_LG_N) | n_idx;

    assign out_rs1 = make_reg_num(REG_FLOAT, 5'(`TCU_RA) + 5'(rs1_off));
    assign out_rs2 = make_reg_num(REG_FLOAT, 5'(`TCU_RB) + 5'(rs2_off));
    assign out_rs3 = make_reg_num(REG_FLOAT, 5'(`TCU_RC) + 5'(rs3_off));
    assign out_rd  = out_rs3;

    // Micro-op index goes in the top bits of the UUID
    assign out_uuid    = {counter, in_uuid[`UUID_WIDTH-TCU_CTR_W-1:0]};
    assign out_tmask   = in_tmask;
    assign out_pc      = in_pc;
    assign out_ex_type = in_ex_type;
    assign out_op_type = in_op_type;
    assign out_fmt_s   = in_fmt_s;
    assign out_fmt_d   = in_fmt_d;
    assign out_wb      = 1'b1;
    assign out_step_m  = 4'(m_idx);
    assign out_step_n  = 4'(n_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else if (!busy && start) begin
            busy <= 1'b1;
            done <= (TCU_UOPS == 1);
        end else if (busy && next) begin
            // Last micro-op taken, so rewind for the next MMA
            counter <= done ? '0 : counter + 1'b1;
            done    <= (counter == TCU_CTR_W'(TCU_UOPS - 2));
            busy    <= !done;
        end
    end

    assert property (@(posedge clk) disable iff (reset) next |-> busy)
        else $error("tcu_uops: next while idle");

endmodule

/* hw/uop_expander.sv */
/*
 * Micro-op expander
 * Passes ordinary instructions straight from the buffer head and runs
 * each TCU MMA through the micro-op generator, popping the head once
 * its last record has been taken
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module uop_expander (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`UUID_WIDTH-1:0]          head_uuid,
    input  logic [gpu_pkg::tmask_w-1:0]     head_tmask,
    input  logic [gpu_pkg::pc_w-1:0]        head_pc,
    input  gpu_pkg::ex_type_e               head_ex_type,
    input  logic [gpu_pkg::op_type_w-1:0]   head_op_type,
    input  tcu_pkg::tcu_fmt_e               head_fmt_s,
    input  tcu_pkg::tcu_fmt_e               head_fmt_d,
    input  logic                            head_wb,
    input  logic [gpu_pkg::reg_num_w-1:0]   head_rd,
    input  logic [gpu_pkg::reg_num_w-1:0]   head_rs1,
    input  logic [gpu_pkg::reg_num_w-1:0]   head_rs2,
    input  logic [gpu_pkg::reg_num_w-1:0]   head_rs3,
    input  logic                            head_valid,
    output logic                            head_pop,
    output logic                            start,
    output logic                            next,
    input  logic                            done,
    input  logic [`UUID_WIDTH-1:0]          uop_uuid,
    input  logic [gpu_pkg::tmask_w-1:0]     uop_tmask,
    input  logic [gpu_pkg::pc_w-1:0]        uop_pc,
    input  gpu_pkg::ex_type_e               uop_ex_type,
    input  logic [gpu_pkg::op_type_w-1:0]   uop_op_type,
    input  tcu_pkg::tcu_fmt_e               uop_fmt_s,
    input  tcu_pkg::tcu_fmt_e               uop_fmt_d,
    input  logic                            uop_wb,
    input  logic [gpu_pkg::reg_num_w-1:0]   uop_rd,
    input  logic [gpu_pkg::reg_num_w-1:0]   uop_rs1,
    input  logic [gpu_pkg::reg_num_w-1:0]   uop_rs2,
    input  logic [gpu_pkg::reg_num_w-1:0]   uop_rs3,
    input  logic [3:0]                      uop_step_m,
    input  logic [3:0]                      uop_step_n,
    output logic [`UUID_WIDTH-1:0]          out_uuid,
    output logic [gpu_pkg::tmask_w-1:0]     out_tmask,
    output logic [gpu_pkg::pc_w-1:0]        out_pc,
    output gpu_pkg::ex_type_e               out_ex_type,
    output logic [gpu_pkg::op_type_w-1:0]   out_op_type,
    output tcu_pkg::tcu_fmt_e               out_fmt_s,
    output tcu_pkg::tcu_fmt_e               out_fmt_d,
    output logic                            out_wb,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rd,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs1,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs2,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs3,
    output logic [3:0]                      out_step_m,
    output logic [3:0]                      out_step_n,
    output logic                            out_valid,
    input  logic                            out_ready
);
    import gpu_pkg::*;
    import tcu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LAUNCH,
        EXPAND
    } state_e;

    state_e state;
    state_e phase;
    logic   head_mma;
    logic   expand;

    assign head_mma = head_valid && (head_ex_type == EX_TCU) && (head_op_type == TCU_MMA);

    // LAUNCH is the first cycle an MMA sits at the head. It is taken from the
    // head directly so start fires without waiting a cycle
    always_comb begin
        phase = state;
        if (state == IDLE && head_mma) begin
            phase = LAUNCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (phase)
                LAUNCH:  state <= EXPAND;
                EXPAND:  if (out_ready && done) state <= IDLE;
                default: ;
            endcase
        end
    end

    assign expand    = (phase == EXPAND);
    assign start     = (phase == LAUNCH);
    assign next      = expand && out_ready;
    assign out_valid = expand || (phase == IDLE && head_valid);
    assign head_pop  = out_valid && out_ready && (phase == IDLE || done);

    assign out_uuid    = expand ? uop_uuid    : head_uuid;
    assign out_tmask   = expand ? uop_tmask   : head_tmask;
    assign out_pc      = expand ? uop_pc      : head_pc;
    assign out_ex_type = expand ? uop_ex_type : head_ex_type;
    assign out_op_type = expand ? uop_op_type : head_op_type;
    assign out_fmt_s   = expand ? uop_fmt_s   : head_fmt_s;
    assign out_fmt_d   = expand ? uop_fmt_d   : head_fmt_d;
    assign out_wb      = expand ? uop_wb      : head_wb;
    assign out_rd      = expand ? uop_rd      : head_rd;
    assign out_rs1     = expand ? uop_rs1     : head_rs1;
    assign out_rs2     = expand ? uop_rs2     : head_rs2;
    assign out_rs3     = expand ? uop_rs3     : head_rs3;
    assign out_step_m  = expand ? uop_step_m  : 4'd0;
    assign out_step_n  = expand ? uop_step_n  : 4'd0;

    // A stalled record holds until it is taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable({out_uuid, out_tmask, out_pc,
            out_ex_type, out_op_type, out_fmt_s, out_fmt_d, out_wb, out_rd, out_rs1,
            out_rs2, out_rs3, out_step_m, out_step_n}))
        else $error("uop_expander: output changed while stalled");

endmodule

/* hw/issue_front.sv */
/*
 * Warp issue front end
 * Instruction buffer feeding the expander, which splits TCU MMA
 * instructions into micro-ops through the micro-op generator
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module issue_front (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`UUID_WIDTH-1:0]          in_uuid,
    input  logic [gpu_pkg::tmask_w-1:0]     in_tmask,
    input  logic [gpu_pkg::pc_w-1:0]        in_pc,
    input  gpu_pkg::ex_type_e               in_ex_type,
    input  logic [gpu_pkg::op_type_w-1:0]   in_op_type,
    input  tcu_pkg::tcu_fmt_e               in_fmt_s,
    input  tcu_pkg::tcu_fmt_e               in_fmt_d,
    input  logic                            in_wb,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rd,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs1,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs2,
    input  logic [gpu_pkg::reg_num_w-1:0]   in_rs3,
    input  logic                            in_valid,
    output logic                            in_ready,
    output logic [`UUID_WIDTH-1:0]          out_uuid,
    output logic [gpu_pkg::tmask_w-1:0]     out_tmask,
    output logic [gpu_pkg::pc_w-1:0]        out_pc,
    output gpu_pkg::ex_type_e               out_ex_type,
    output logic [gpu_pkg::op_type_w-1:0]   out_op_type,
    output tcu_pkg::tcu_fmt_e               out_fmt_s,
    output tcu_pkg::tcu_fmt_e               out_fmt_d,
    output logic                            out_wb,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rd,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs1,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs2,
    output logic [gpu_pkg::reg_num_w-1:0]   out_rs3,
    output logic [3:0]                      out_step_m,
    output logic [3:0]                      out_step_n,
    output logic                            out_valid,
    input  logic                            out_ready
);
    import gpu_pkg::*;
    import tcu_pkg::*;

    // Buffer head
    logic [`UUID_WIDTH-1:0] head_uuid;
    logic [tmask_w-1:0]     head_tmask;
    logic [pc_w-1:0]        head_pc;
    ex_type_e               head_ex_type;
    logic [op_type_w-1:0]   head_op_type;
    tcu_fmt_e               head_fmt_s;
    tcu_fmt_e               head_fmt_d;
    logic                   head_wb;
    logic [reg_num_w-1:0]   head_rd;
    logic [reg_num_w-1:0]   head_rs1;
    logic [reg_num_w-1:0]   head_rs2;
    logic [reg_num_w-1:0]   head_rs3;
    logic                   head_valid;
    logic                   head_pop;

    // Micro-op generator control and record
    logic                   start;
    logic                   next;
    logic                   done;
    logic [`UUID_WIDTH-1:0] uop_uuid;
    logic [tmask_w-1:0]     uop_tmask;
    logic [pc_w-1:0]        uop_pc;
    ex_type_e               uop_ex_type;
    logic [op_type_w-1:0]   uop_op_type;
    tcu_fmt_e               uop_fmt_s;
    tcu_fmt_e               uop_fmt_d;
    logic                   uop_wb;
    logic [reg_num_w-1:0]   uop_rd;
    logic [reg_num_w-1:0]   uop_rs1;
    logic [reg_num_w-1:0]   uop_rs2;
    logic [reg_num_w-1:0]   uop_rs3;
    logic [3:0]             uop_step_m;
    logic [3:0]             uop_step_n;

    // Buffer and expander port names match the nets above one for one
    ibuffer_fifo #(
        .DEPTH(`IBUF_DEPTH)
    ) u_ibuffer (.*);

    uop_expander u_expander (.*);

    tcu_uops u_tcu_uops (
        .clk         (clk),
        .reset       (reset),
        .in_uuid     (head_uuid),
        .in_tmask    (head_tmask),
        .in_pc       (head_pc),
        .in_ex_type  (head_ex_type),
        .in_op_type  (head_op_type),
        .in_fmt_s    (head_fmt_s),
        .in_fmt_d    (head_fmt_d),
        .start       (start),
        .next        (next),
        .done        (done),
        .out_uuid    (uop_uuid),
        .out_tmask   (uop_tmask),
        .out_pc      (uop_pc),
        .out_ex_type (uop_ex_type),
        .out_op_type (uop_op_type),
        .out_fmt_s   (uop_fmt_s),
        .out_fmt_d   (uop_fmt_d),
        .out_wb      (uop_wb),
        .out_rd      (uop_rd),
        .out_rs1     (uop_rs1),
        .out_rs2     (uop_rs2),
        .out_rs3     (uop_rs3),
        .out_step_m  (uop_step_m),
        .out_step_n  (uop_step_n)
    );

endmodule

/* test/tb_issue_front.sv */
/*
 * Issue front testbench
 * Sends random plain and TCU instructions under random back-pressure,
 * expands each into its expected records and checks every output
 * transfer in order, then fills the buffer with the output stalled
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module tb_issue_front;
    import gpu_pkg::*;
    import tcu_pkg::*;

    typedef struct packed {
        logic [`UUID_WIDTH-1:0] uuid;
        logic [3:0]             tmask;
        logic [31:0]            pc;
        logic [1:0]             ex_type;
        logic [3:0]             op_type;
        logic [2:0]             fmt_s;
        logic [2:0]             fmt_d;
        logic                   wb;
        logic [5:0]             rd;
        logic [5:0]             rs1;
        logic [5:0]             rs2;
        logic [5:0]             rs3;
        logic [3:0]             step_m;
        logic [3:0]             step_n;
    } rec_t;

    localparam int random_count   = 36;
    localparam int timeout_cycles = 40 * (TCU_UOPS + 2) * 4;
    localparam int ctr_w          = (TCU_UOPS > 1) ? $clog2(TCU_UOPS) : 1;
    localparam int lg_n           = $clog2(`TCU_N_STEPS);
    localparam int lg_k           = $clog2(`TCU_K_STEPS);
    localparam int lg_a_sb        = $clog2(`TCU_A_SUB_BLOCKS);
    localparam int lg_b_sb        = $clog2(`TCU_B_SUB_BLOCKS);

    logic clk;
    logic reset;
    logic [`UUID_WIDTH-1:0] in_uuid, out_uuid;
    logic [3:0]  in_tmask, out_tmask;
    logic [31:0] in_pc, out_pc;
    ex_type_e    in_ex_type, out_ex_type;
    logic [3:0]  in_op_type, out_op_type;
    tcu_fmt_e    in_fmt_s, in_fmt_d, out_fmt_s, out_fmt_d;
    logic        in_wb, out_wb;
    logic [5:0]  in_rd, in_rs1, in_rs2, in_rs3;
    logic [5:0]  out_rd, out_rs1, out_rs2, out_rs3;
    logic [3:0]  out_step_m, out_step_n;
    logic        in_valid, in_ready, out_valid, out_ready;

    rec_t        expected_q[$];
    logic [15:0] lfsr_state = 16'd20286;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          records_seen = 0;
    int          cycle_count;

    issue_front u_issue_front (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Each bit taken costs one LFSR step and is the state's low bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // High in 11 cycles out of 16
    function automatic logic pick_ready();
        return take_bits(4) < 32'd11;
    endfunction

    function automatic logic is_mma(rec_t ins);
        return (ins.ex_type == EX_TCU) && (ins.op_type == TCU_MMA);
    endfunction

    // Expected record of a plain instruction, or of micro-op idx at tile step m, n, k
    function automatic rec_t expected_record(rec_t ins, int idx, int m, int n, int k);
        rec_t r;
        logic [4:0] a_idx;
        logic [4:0] b_idx;
        logic [4:0] c_idx;
        r = ins;
        r.step_m = '0;
        r.step_n = '0;
        if (!is_mma(ins)) begin
            return r;
        end
        a_idx = 5'(`TCU_RA + (((m >> lg_a_sb) << lg_k) | k));
        b_idx = 5'(`TCU_RB + (((k << lg_n) | n) >> lg_b_sb));
        c_idx = 5'(`TCU_RC + ((m << lg_n) | n));
        r.rs1 = {1'b1, a_idx};
        r.rs2 = {1'b1, b_idx};
        r.rs3 = {1'b1, c_idx};
        r.rd = r.rs3;
        r.wb = 1'b1;
        r.uuid = (ins.uuid & ({`UUID_WIDTH{1'b1}} >> ctr_w))
               | (`UUID_WIDTH'(idx) << (`UUID_WIDTH - ctr_w));
        r.step_m = 4'(m);
        r.step_n = 4'(n);
        return r;
    endfunction

    // Micro-ops come out with N fastest, then M, then K
    task automatic add_expected(input rec_t ins);
        int idx;
        idx = 0;
        if (!is_mma(ins)) begin
            expected_q.push_back(expected_record(ins, 0, 0, 0, 0));
        end else begin
            for (int k = 0; k < `TCU_K_STEPS; k++) begin
                for (int m = 0; m < `TCU_M_STEPS; m++) begin
                    for (int n = 0; n < `TCU_N_STEPS; n++) begin
                        expected_q.push_back(expected_record(ins, idx, m, n, k));
                        idx++;
                    end
                end
            end
        end
    endtask

    task automatic make_instr(output rec_t ins);
        logic [31:0] kind;
        kind = take_bits(3);
        ins.uuid = `UUID_WIDTH'(take_bits(`UUID_WIDTH));
        ins.tmask = 4'(take_bits(4));
        ins.pc = take_bits(32);
        ins.op_type = 4'(take_bits(4));
        ins.fmt_s = 3'(take_bits(2));
        ins.fmt_d = 3'(take_bits(2));
        ins.wb = 1'(take_bits(1));
        ins.rd = 6'(take_bits(6));
        ins.rs1 = 6'(take_bits(6));
        ins.rs2 = 6'(take_bits(6));
        ins.rs3 = 6'(take_bits(6));
        ins.step_m = '0;
        ins.step_n = '0;
        // Half of all instructions are MMAs
        case (kind)
            32'd0: ins.ex_type = EX_ALU;
            32'd1: ins.ex_type = EX_LSU;
            32'd2: ins.ex_type = EX_SFU;
            32'd3: begin
                ins.ex_type = EX_TCU;
                ins.op_type = TCU_ZERO;
            end
            default: begin
                ins.ex_type = EX_TCU;
                ins.op_type = TCU_MMA;
            end
        endcase
    endtask

    task automatic drive_instr(input rec_t ins);
        in_uuid    = ins.uuid;
        in_tmask   = ins.tmask;
        in_pc      = ins.pc;
        in_ex_type = ex_type_e'(ins.ex_type);
        in_op_type = ins.op_type;
        in_fmt_s   = tcu_fmt_e'(ins.fmt_s);
        in_fmt_d   = tcu_fmt_e'(ins.fmt_d);
        in_wb      = ins.wb;
        in_rd      = ins.rd;
        in_rs1     = ins.rs1;
        in_rs2     = ins.rs2;
        in_rs3     = ins.rs3;
        in_valid   = 1'b1;
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_record(input rec_t e);
        check_field("out_uuid", 32'(e.uuid), 32'(out_uuid));
        check_field("out_tmask", 32'(e.tmask), 32'(out_tmask));
        check_field("out_pc", e.pc, out_pc);
        check_field("out_ex_type", 32'(e.ex_type), 32'(out_ex_type));
        check_field("out_op_type", 32'(e.op_type), 32'(out_op_type));
        check_field("out_fmt_s", 32'(e.fmt_s), 32'(out_fmt_s));
        check_field("out_fmt_d", 32'(e.fmt_d), 32'(out_fmt_d));
        check_field("out_wb", 32'(e.wb), 32'(out_wb));
        check_field("out_rd", 32'(e.rd), 32'(out_rd));
        check_field("out_rs1", 32'(e.rs1), 32'(out_rs1));
        check_field("out_rs2", 32'(e.rs2), 32'(out_rs2));
        check_field("out_rs3", 32'(e.rs3), 32'(out_rs3));
        check_field("out_step_m", 32'(e.step_m), 32'(out_step_m));
        check_field("out_step_n", 32'(e.step_n), 32'(out_step_n));
    endtask

    // Outputs are settled by the falling edge; the transfer itself
    // happens on the rising edge that follows
    always @(negedge clk) begin : compare_outputs
        rec_t expected_rec;
        if (!reset && out_valid && out_ready) begin
            assert (expected_q.size() != 0) else begin
                other_count++;
                $display("error at %0t ns: output record with nothing left to expect", $time);
            end
            if (expected_q.size() != 0) begin
                expected_rec = expected_q.pop_front();
                compare_record(expected_rec);
                records_seen++;
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        rec_t ins;
        logic accepted;
        int   filled;
        reset = 1'b1;
        in_uuid = '0;
        in_tmask = '0;
        in_pc = '0;
        in_ex_type = EX_ALU;
        in_op_type = '0;
        in_fmt_s = FMT_FP16;
        in_fmt_d = FMT_FP16;
        in_wb = 1'b0;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_rs3 = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_field("out_valid", 32'd0, 32'(out_valid));
        check_field("in_ready", 32'd1, 32'(in_ready));

        // Mixed traffic under random back-pressure
        for (int i = 0; i < random_count; i++) begin
            make_instr(ins);
            drive_instr(ins);
            accepted = 1'b0;
            while (!accepted) begin
                accepted = in_ready;
                out_ready = pick_ready();
                @(posedge clk);
                #1;
            end
            add_expected(ins);
        end
        in_valid = 1'b0;
        while (expected_q.size() != 0) begin
            out_ready = pick_ready();
            @(posedge clk);
            #1;
        end

        // With the output stalled the buffer takes exactly its depth
        out_ready = 1'b0;
        filled = 0;
        while (in_ready && filled <= `IBUF_DEPTH) begin
            make_instr(ins);
            drive_instr(ins);
            @(posedge clk);
            #1;
            filled++;
            add_expected(ins);
        end
        in_valid = 1'b0;
        check_field("accepted_count", 32'(`IBUF_DEPTH), 32'(filled));
        check_field("in_ready", 32'd0, 32'(in_ready));
        out_ready = 1'b1;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (TCU_UOPS + 2) @(posedge clk);
        #1;
        check_field("out_valid", 32'd0, 32'(out_valid));

        $display("errors: mismatches %0d, other %0d, records checked %0d",
                 mismatch_count, other_count, records_seen);
        if (mismatch_count == 0 && other_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* issue_front.f */
+incdir+hw
hw/gpu_pkg.sv
hw/tcu_pkg.sv
hw/ibuffer_fifo.sv
hw/tcu_uops.sv
hw/uop_expander.sv
hw/issue_front.sv
test/tb_issue_front.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the issue front testbench with Verilator and runs it.
# The status is failing unless the simulation output holds the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f issue_front.f --top-module tb_issue_front \
    && ./obj_dir/Vtb_issue_front | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
